//--- hdl/pd_payload.sv
// ======================================
// Payload stage. Shifts DATA0 header and
// DATA1 target bytes into a staging
// register, checks meta code and length,
// and publishes the hasher inputs.
// ======================================
`timescale 1ns/1ps
`default_nettype none

module pd_payload
(
	input  wire logic                                 tb_clk,
	input  wire logic                                 rst_n,
	input  wire pd_pkg::pid_info_t                    pid_info,
	input  wire pd_pkg::token_state_t                 token,
	output pd_pkg::payload_status_t                   status,
	output logic [pd_pkg::HEADER_BYTES*8-1:0]         data_to_hash,
	output logic [pd_pkg::TARGET_BYTES*8-1:0]         difficulty
);

	localparam logic [6:0] HDR_CNT = 7'(pd_pkg::HEADER_BYTES);
	localparam logic [6:0] TGT_CNT = 7'(pd_pkg::TARGET_BYTES);
	localparam logic [6:0] CNT_MAX = 7'h7F;

	logic                              meta_seen;
	pd_pkg::meta_e                     meta_q;
	logic [6:0]                        byte_cnt;
	logic [pd_pkg::HEADER_BYTES*8-1:0] stage;
	logic                              is_data;
	logic                              is_data0;
	logic                              meta_slot;
	logic                              hash_ok;
	logic                              intr_ok;
	logic                              data_ok;

	assign is_data0  = (pid_info.kind == pd_pkg::pid_data0);
	assign is_data   = is_data0 || (pid_info.kind == pd_pkg::pid_data1);
	assign meta_slot = is_data0 && !meta_seen;

	always_ff @(posedge tb_clk)
	begin
		if (!rst_n)
		begin
			meta_seen <= 1'b0;
			byte_cnt  <= '0;
		end
		else if (pid_info.pkt_start)
		begin
			meta_seen <= 1'b0;
			byte_cnt  <= '0;
		end
		else if (pid_info.body_strobe && is_data)
		begin
			if (meta_slot)
				meta_seen <= 1'b1;
			else if (byte_cnt != CNT_MAX)
				byte_cnt <= byte_cnt + 7'd1;
		end
	end

	// Most significant byte arrives first
	always_ff @(posedge tb_clk)
	begin
		if (pid_info.body_strobe && is_data)
		begin
			if (meta_slot)
				meta_q <= pd_pkg::meta_e'(pid_info.body_data);
			else
				stage <= {stage[pd_pkg::HEADER_BYTES*8-9:0], pid_info.body_data};
		end
	end

	assign hash_ok = meta_seen && (meta_q == pd_pkg::meta_hash) && (byte_cnt == HDR_CNT);
	assign intr_ok = meta_seen && (meta_q == pd_pkg::meta_interrupt) && (byte_cnt == 7'd0);

	always_comb
	begin
		case (pid_info.kind)
			pd_pkg::pid_data0: data_ok = token.out_open && (hash_ok || intr_ok);
			pd_pkg::pid_data1: data_ok = token.out_open && (byte_cnt == TGT_CNT);
			default:           data_ok = 1'b0;
		endcase
	end

	// Levels, read by the response stage at pkt_end
	assign status = '{data_ok: data_ok,
		data_err: is_data && !data_ok,
		interrupt: data_ok && is_data0 && intr_ok,
		header_valid: data_ok && is_data0 && hash_ok,
		target_valid: data_ok && (pid_info.kind == pd_pkg::pid_data1)};

	always_ff @(posedge tb_clk)
	begin
		if (!rst_n)
		begin
			data_to_hash <= '0;
			difficulty   <= '0;
		end
		else if (pid_info.pkt_end)
		begin
			if (status.header_valid)
				data_to_hash <= stage;
			// Target sits in the low end after 32 shifts
			if (status.target_valid)
				difficulty <= stage[pd_pkg::TARGET_BYTES*8-1:0];
		end
	end

endmodule

`default_nettype wire

//--- hdl/pd_pid_decode.sv
// ======================================
// First stage of the packet decoder.
// Finds the PID byte of each packet,
// checks and classifies it, and forwards
// body bytes and end of packet.
// ======================================
`timescale 1ns/1ps
`default_nettype none

module pd_pid_decode
(
	input  wire logic              tb_clk,
	input  wire logic              rst_n,
	input  wire logic              write_enable,
	input  wire logic [7:0]        rx_data,
	input  wire logic              eop,
	output pd_pkg::pid_info_t      pid_info,
	output pd_pkg::pid_kind_e      packet_type,
	output logic                   p_error
);

	logic              first_byte;
	logic              pkt_start_q;
	logic              body_strobe_q;
	logic [7:0]        body_data_q;
	logic              pkt_end_q;
	pd_pkg::pid_kind_e kind_q;
	pd_pkg::pid_kind_e pid_class;

	// Nibble check first, then the known codes
	function automatic pd_pkg::pid_kind_e classify(input logic [7:0] code);
		pd_pkg::pid_kind_e kind;
		kind = pd_pkg::pid_bad;
		if (code[7:4] == ~code[3:0])
		begin
			case (code)
				pd_pkg::PID_IN:    kind = pd_pkg::pid_in;
				pd_pkg::PID_OUT:   kind = pd_pkg::pid_out;
				pd_pkg::PID_DATA0: kind = pd_pkg::pid_data0;
				pd_pkg::PID_DATA1: kind = pd_pkg::pid_data1;
				default:           kind = pd_pkg::pid_bad;
			endcase
		end
		return kind;
	endfunction

	assign pid_class = classify(rx_data);

	always_ff @(posedge tb_clk)
	begin
		if (!rst_n)
		begin
			first_byte    <= 1'b1;
			pkt_start_q   <= 1'b0;
			body_strobe_q <= 1'b0;
			pkt_end_q     <= 1'b0;
			kind_q        <= pd_pkg::pid_bad;
			packet_type   <= pd_pkg::pid_bad;
			p_error       <= 1'b0;
		end
		else
		begin
			pkt_start_q   <= write_enable && first_byte;
			body_strobe_q <= write_enable && !first_byte;
			pkt_end_q     <= eop;
			if (eop)
				first_byte <= 1'b1;
			else if (write_enable)
				first_byte <= 1'b0;
			if (write_enable && first_byte)
			begin
				kind_q      <= pid_class;
				packet_type <= pid_class;
				p_error     <= (pid_class == pd_pkg::pid_bad);
			end
		end
	end

	// Body byte is only meaningful with its strobe
	always_ff @(posedge tb_clk)
	begin
		if (write_enable)
			body_data_q <= rx_data;
	end

	assign pid_info = '{pkt_start: pkt_start_q, kind: kind_q, body_strobe: body_strobe_q,
		body_data: body_data_q, pkt_end: pkt_end_q};

endmodule

`default_nettype wire

//--- hdl/pd_pkg.sv
// ======================================
// Shared types and constants for the
// packet decoder. Every RTL stage refers
// to these through pd_pkg:: names.
// ======================================
`default_nettype none

package pd_pkg;

	// Packet kinds after PID classification
	typedef enum logic [2:0]
	{
		pid_in,
		pid_out,
		pid_data0,
		pid_data1,
		pid_bad
	} pid_kind_e;

	// PID bytes, complement nibble on top
	localparam logic [7:0] PID_IN    = 8'h69;
	localparam logic [7:0] PID_OUT   = 8'hE1;
	localparam logic [7:0] PID_DATA0 = 8'hC3;
	localparam logic [7:0] PID_DATA1 = 8'h4B;

	// First body byte of a DATA0 packet
	typedef enum logic [7:0]
	{
		meta_hash      = 8'h01,
		meta_interrupt = 8'h04
	} meta_e;

	localparam int HEADER_BYTES = 64;
	localparam int TARGET_BYTES = 32;

	typedef struct packed
	{
		logic      pkt_start;
		pid_kind_e kind;
		logic      body_strobe;
		logic [7:0] body_data;
		logic      pkt_end;
	} pid_info_t;

	typedef struct packed
	{
		logic out_open;
		logic in_pending;
		logic addr_ok;
		logic token_err;
	} token_state_t;

	typedef struct packed
	{
		logic data_ok;
		logic data_err;
		logic interrupt;
		logic header_valid;
		logic target_valid;
	} payload_status_t;

endpackage

`default_nettype wire

//--- hdl/pd_response.sv
// ======================================
// Response stage. Answers every packet
// with ack or nack, starts the hasher
// once header and target are both held,
// and tracks the hasher's result.
// ======================================
`timescale 1ns/1ps
`default_nettype none

module pd_response
(
	input  wire logic                    tb_clk,
	input  wire logic                    rst_n,
	input  wire pd_pkg::pid_info_t       pid_info,
	input  wire pd_pkg::token_state_t    token,
	input  wire pd_pkg::payload_status_t status,
	input  wire logic                    hash_done,
	output logic                         transmit_ack,
	output logic                         transmit_nack,
	output logic                         rcv_error,
	output logic                         new_block,
	output logic                         hash_abort,
	output logic                         host_ready
);

	logic result_pending;
	logic hdr_held;
	logic tgt_held;
	logic hdr_next;
	logic tgt_next;

	assign hdr_next = hdr_held || (pid_info.pkt_end && status.header_valid);
	assign tgt_next = tgt_held || (pid_info.pkt_end && status.target_valid);

	always_ff @(posedge tb_clk)
	begin
		if (!rst_n)
		begin
			transmit_ack   <= 1'b0;
			transmit_nack  <= 1'b0;
			rcv_error      <= 1'b0;
			new_block      <= 1'b0;
			hash_abort     <= 1'b0;
			host_ready     <= 1'b1;
			result_pending <= 1'b0;
			hdr_held       <= 1'b0;
			tgt_held       <= 1'b0;
		end
		else
		begin
			transmit_ack  <= 1'b0;
			transmit_nack <= 1'b0;
			rcv_error     <= 1'b0;
			new_block     <= 1'b0;
			hash_abort    <= 1'b0;

			if (hash_done)
			begin
				result_pending <= 1'b1;
				host_ready     <= 1'b1;
			end

			if (pid_info.pkt_end)
			begin
				if (pid_info.kind == pd_pkg::pid_bad)
					transmit_nack <= 1'b1;
				else if (token.token_err || status.data_err)
				begin
					transmit_nack <= 1'b1;
					rcv_error     <= 1'b1;
				end
				else if (token.in_pending)
				begin
					// IN is acked only with a result to hand over
					transmit_ack   <= result_pending;
					transmit_nack  <= !result_pending;
					result_pending <= 1'b0;
				end
				else if (token.addr_ok || status.data_ok)
					transmit_ack <= 1'b1;
				else
					transmit_nack <= 1'b1;

				if (status.interrupt)
				begin
					hash_abort <= 1'b1;
					host_ready <= 1'b1;
				end
			end

			// Both halves of the block consumed together
			if (host_ready && hdr_next && tgt_next)
			begin
				new_block  <= 1'b1;
				host_ready <= 1'b0;
				hdr_held   <= 1'b0;
				tgt_held   <= 1'b0;
			end
			else
			begin
				hdr_held <= hdr_next;
				tgt_held <= tgt_next;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/pd_token_check.sv
// ======================================
// Token stage. Matches the address byte
// of IN and OUT tokens against DEV_ADDR
// and keeps the OUT transaction open for
// the DATA packet that follows it.
// ======================================
`timescale 1ns/1ps
`default_nettype none

module pd_token_check
#(
	parameter logic [6:0] DEV_ADDR = 7'h15
)
(
	input  wire logic                 tb_clk,
	input  wire logic                 rst_n,
	input  wire pd_pkg::pid_info_t    pid_info,
	output pd_pkg::token_state_t      token
);

	logic addr_seen;
	logic addr_ok;
	logic out_open;
	logic is_token;

	assign is_token = (pid_info.kind == pd_pkg::pid_in) || (pid_info.kind == pd_pkg::pid_out);

	always_ff @(posedge tb_clk)
	begin
		if (!rst_n)
		begin
			addr_seen <= 1'b0;
			addr_ok   <= 1'b0;
			out_open  <= 1'b0;
		end
		else
		begin
			if (pid_info.pkt_start)
			begin
				addr_seen <= 1'b0;
				addr_ok   <= 1'b0;
			end
			else if (pid_info.body_strobe && is_token && !addr_seen)
			begin
				// Only the first body byte carries the address
				addr_seen <= 1'b1;
				addr_ok   <= (pid_info.body_data[6:0] == DEV_ADDR);
			end

			// Any packet other than a good OUT closes the transaction
			if (pid_info.pkt_end)
				out_open <= (pid_info.kind == pd_pkg::pid_out) && addr_ok;
		end
	end

	assign token = '{out_open: out_open,
		in_pending: (pid_info.kind == pd_pkg::pid_in) && addr_ok,
		addr_ok: addr_ok,
		token_err: is_token && !addr_ok};

endmodule

`default_nettype wire

//--- hdl/pd_top.sv
// ======================================
// Packet decoder top level. Takes bytes
// and end-of-packet pulses from the
// serial front end and drives the ack
// lines and the hasher interface.
// ======================================
`timescale 1ns/1ps
`default_nettype none

module pd_top
#(
	parameter logic [6:0] DEV_ADDR = 7'h15
)
(
	input  wire logic                                 tb_clk,
	input  wire logic                                 rst_n,
	input  wire logic                                 write_enable,
	input  wire logic [7:0]                           rx_data,
	input  wire logic                                 eop,
	input  wire logic                                 hash_done,
	output pd_pkg::pid_kind_e                         packet_type,
	output logic                                      p_error,
	output logic                                      rcv_error,
	output logic                                      transmit_ack,
	output logic                                      transmit_nack,
	output logic                                      new_block,
	output logic                                      host_ready,
	output logic                                      hash_abort,
	output logic [pd_pkg::HEADER_BYTES*8-1:0]         data_to_hash,
	output logic [pd_pkg::TARGET_BYTES*8-1:0]         difficulty
);

	pd_pkg::pid_info_t       pid_info;
	pd_pkg::token_state_t    token;
	pd_pkg::payload_status_t status;

	pd_pid_decode pd_pid_decode_i
	(
		.tb_clk       (tb_clk),
		.rst_n        (rst_n),
		.write_enable (write_enable),
		.rx_data      (rx_data),
		.eop          (eop),
		.pid_info     (pid_info),
		.packet_type  (packet_type),
		.p_error      (p_error)
	);

	pd_token_check #(.DEV_ADDR(DEV_ADDR)) pd_token_check_i
	(
		.tb_clk   (tb_clk),
		.rst_n    (rst_n),
		.pid_info (pid_info),
		.token    (token)
	);

	pd_payload pd_payload_i
	(
		.tb_clk       (tb_clk),
		.rst_n        (rst_n),
		.pid_info     (pid_info),
		.token        (token),
		.status       (status),
		.data_to_hash (data_to_hash),
		.difficulty   (difficulty)
	);

	pd_response pd_response_i
	(
		.tb_clk        (tb_clk),
		.rst_n         (rst_n),
		.pid_info      (pid_info),
		.token         (token),
		.status        (status),
		.hash_done     (hash_done),
		.transmit_ack  (transmit_ack),
		.transmit_nack (transmit_nack),
		.rcv_error     (rcv_error),
		.new_block     (new_block),
		.hash_abort    (hash_abort),
		.host_ready    (host_ready)
	);

endmodule

`default_nettype wire

//--- packet_decoder.f
hdl/pd_pkg.sv
hdl/pd_pid_decode.sv
hdl/pd_token_check.sv
hdl/pd_payload.sv
hdl/pd_response.sv
hdl/pd_top.sv
verif/pd_asserts.sv
verif/tb_pd_top.sv

//--- verif/pd_asserts.sv
// ======================================
// Concurrent assertions on the response
// stage, bound into pd_response by the
// testbench. fail_count is read there.
// ======================================
`timescale 1ns/1ps
`default_nettype none

module pd_asserts
(
	input wire logic tb_clk,
	input wire logic rst_n,
	input wire logic transmit_ack,
	input wire logic transmit_nack,
	input wire logic rcv_error,
	input wire logic new_block,
	input wire logic hash_abort,
	input wire logic host_ready
);

	int fail_count = 0;

	ack_nack_exclusive: assert property (@(posedge tb_clk) disable iff (!rst_n)
		!(transmit_ack && transmit_nack))
	else
	begin
		$error("transmit_ack and transmit_nack high together");
		fail_count++;
	end

	// Block start hands the hasher the inputs
	new_block_drops_ready: assert property (@(posedge tb_clk) disable iff (!rst_n)
		new_block |-> $fell(host_ready))
	else
	begin
		$error("new_block without host_ready falling");
		fail_count++;
	end

	quiet_after_reset: assert property (@(posedge tb_clk)
		!rst_n |=> (!transmit_ack && !transmit_nack && !rcv_error && !new_block
			&& !hash_abort && host_ready))
	else
	begin
		$error("response outputs not in reset state after reset");
		fail_count++;
	end

endmodule

`default_nettype wire

//--- verif/tb_pd_top.sv
// ======================================
// Directed testbench for the packet
// decoder. Sends token and DATA packets
// byte by byte and checks the ack lines,
// the hasher outputs and host_ready.
// ======================================
`timescale 1ns/1ps
`default_nettype none

module tb_pd_top;

	localparam logic [6:0] DEV_ADDR = 7'h15;
	localparam int RESP_TIMEOUT = 20;
	localparam int HDR_W = pd_pkg::HEADER_BYTES * 8;
	localparam int TGT_W = pd_pkg::TARGET_BYTES * 8;

	logic              tb_clk;
	logic              rst_n;
	logic              write_enable;
	logic [7:0]        rx_data;
	logic              eop;
	logic              hash_done;
	pd_pkg::pid_kind_e packet_type;
	logic              p_error;
	logic              rcv_error;
	logic              transmit_ack;
	logic              transmit_nack;
	logic              new_block;
	logic              host_ready;
	logic              hash_abort;
	logic [HDR_W-1:0]  data_to_hash;
	logic [TGT_W-1:0]  difficulty;

	// Expected payloads, first byte sent is index 0
	logic [7:0] header_bytes [pd_pkg::HEADER_BYTES];
	logic [7:0] target_bytes [pd_pkg::TARGET_BYTES];
	int         errors;
	int         tests_run;
	int         tests_failed;
	logic       resp_host_ready;
	int         seed_init;

	pd_top #(.DEV_ADDR(DEV_ADDR)) pd_top_i
	(
		.tb_clk        (tb_clk),
		.rst_n         (rst_n),
		.write_enable  (write_enable),
		.rx_data       (rx_data),
		.eop           (eop),
		.hash_done     (hash_done),
		.packet_type   (packet_type),
		.p_error       (p_error),
		.rcv_error     (rcv_error),
		.transmit_ack  (transmit_ack),
		.transmit_nack (transmit_nack),
		.new_block     (new_block),
		.host_ready    (host_ready),
		.hash_abort    (hash_abort),
		.data_to_hash  (data_to_hash),
		.difficulty    (difficulty)
	);

	bind pd_response pd_asserts pd_asserts_i
	(
		.tb_clk        (tb_clk),
		.rst_n         (rst_n),
		.transmit_ack  (transmit_ack),
		.transmit_nack (transmit_nack),
		.rcv_error     (rcv_error),
		.new_block     (new_block),
		.hash_abort    (hash_abort),
		.host_ready    (host_ready)
	);

	initial
	begin
		tb_clk = 1'b0;
		forever #50 tb_clk = ~tb_clk;
	end

	task automatic check_value(input string name, input logic [HDR_W-1:0] actual,
		input logic [HDR_W-1:0] expected);
		if (actual !== expected)
		begin
			$display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests_run++;
		if (errors == start_errors)
			$display("%s: ok", name);
		else
		begin
			tests_failed++;
			$display("%s: %0d mismatches", name, errors - start_errors);
		end
	endtask

	task automatic send_byte(input logic [7:0] value);
		@(posedge tb_clk);
		write_enable <= 1'b1;
		rx_data      <= value;
		@(posedge tb_clk);
		write_enable <= 1'b0;
		repeat (2) @(posedge tb_clk);
	endtask

	task automatic send_eop();
		@(posedge tb_clk);
		eop <= 1'b1;
		@(posedge tb_clk);
		eop <= 1'b0;
	endtask

	task automatic send_token(input logic [7:0] pid, input logic [6:0] addr);
		send_byte(pid);
		send_byte({1'b0, addr});
		send_eop();
	endtask

	task automatic pulse_hash_done();
		@(posedge tb_clk);
		hash_done <= 1'b1;
		@(posedge tb_clk);
		hash_done <= 1'b0;
	endtask

	// Header as the hasher sees it, first byte on top
	function automatic logic [HDR_W-1:0] packed_header();
		logic [HDR_W-1:0] v;
		for (int i = 0; i < pd_pkg::HEADER_BYTES; i++)
			v[HDR_W-1-8*i -: 8] = header_bytes[i];
		return v;
	endfunction

	function automatic logic [TGT_W-1:0] packed_target();
		logic [TGT_W-1:0] v;
		for (int i = 0; i < pd_pkg::TARGET_BYTES; i++)
			v[TGT_W-1-8*i -: 8] = target_bytes[i];
		return v;
	endfunction

	task automatic fill_block();
		for (int i = 0; i < pd_pkg::HEADER_BYTES; i++)
			header_bytes[i] = 8'($urandom);
		for (int i = 0; i < pd_pkg::TARGET_BYTES; i++)
			target_bytes[i] = 8'($urandom);
	endtask

	task automatic send_header(input int count);
		send_byte(pd_pkg::PID_DATA0);
		send_byte(pd_pkg::meta_hash);
		for (int i = 0; i < count; i++)
			send_byte(header_bytes[i]);
		send_eop();
	endtask

	task automatic send_target();
		send_byte(pd_pkg::PID_DATA1);
		for (int i = 0; i < pd_pkg::TARGET_BYTES; i++)
			send_byte(target_bytes[i]);
		send_eop();
	endtask

	// Call right after send_eop, pulses due two cycles later
	task automatic expect_response(input string what, input logic exp_ack,
		input logic exp_rcv, input logic exp_new_block, input logic exp_abort);
		int   cycles;
		logic seen;
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < RESP_TIMEOUT)
		begin
			@(negedge tb_clk);
			cycles++;
			if (transmit_ack || transmit_nack)
				seen = 1'b1;
		end
		if (!seen)
		begin
			$display("%s: no ack or nack within %0d cycles after eop", what, RESP_TIMEOUT);
			errors++;
		end
		else
		begin
			resp_host_ready = host_ready;
			check_value({what, " latency"}, cycles, 2);
			check_value({what, " transmit_ack"}, transmit_ack, exp_ack);
			check_value({what, " transmit_nack"}, transmit_nack, !exp_ack);
			check_value({what, " rcv_error"}, rcv_error, exp_rcv);
			check_value({what, " new_block"}, new_block, exp_new_block);
			check_value({what, " hash_abort"}, hash_abort, exp_abort);
			@(negedge tb_clk);
			check_value({what, " ack after pulse"}, transmit_ack, 1'b0);
			check_value({what, " nack after pulse"}, transmit_nack, 1'b0);
		end
	endtask

	// OUT, DATA0 header, OUT, DATA1 target
	task automatic load_block();
		send_token(pd_pkg::PID_OUT, DEV_ADDR);
		expect_response("OUT before DATA0", 1'b1, 1'b0, 1'b0, 1'b0);
		send_header(pd_pkg::HEADER_BYTES);
		expect_response("DATA0 header", 1'b1, 1'b0, 1'b0, 1'b0);
		send_token(pd_pkg::PID_OUT, DEV_ADDR);
		expect_response("OUT before DATA1", 1'b1, 1'b0, 1'b0, 1'b0);
		send_target();
		expect_response("DATA1 target", 1'b1, 1'b0, 1'b1, 1'b0);
	endtask

	task automatic test_reset_and_out();
		int start;
		start = errors;
		@(negedge tb_clk);
		check_value("host_ready", host_ready, 1'b1);
		check_value("transmit_ack", transmit_ack, 1'b0);
		check_value("transmit_nack", transmit_nack, 1'b0);
		check_value("rcv_error", rcv_error, 1'b0);
		check_value("new_block", new_block, 1'b0);
		check_value("hash_abort", hash_abort, 1'b0);
		check_value("packet_type", packet_type, pd_pkg::pid_bad);
		check_value("data_to_hash", data_to_hash, '0);
		check_value("difficulty", difficulty, '0);
		send_token(pd_pkg::PID_OUT, DEV_ADDR);
		expect_response("OUT own address", 1'b1, 1'b0, 1'b0, 1'b0);
		check_value("packet_type after OUT", packet_type, pd_pkg::pid_out);
		check_value("p_error after OUT", p_error, 1'b0);
		send_token(pd_pkg::PID_OUT, DEV_ADDR ^ 7'h01);
		expect_response("OUT other address", 1'b0, 1'b1, 1'b0, 1'b0);
		report_test("reset and OUT token", start);
	endtask

	task automatic test_bad_pid();
		int start;
		start = errors;
		// High nibble E is not the complement of 2
		send_byte(8'hE2);
		@(negedge tb_clk);
		check_value("p_error", p_error, 1'b1);
		check_value("packet_type", packet_type, pd_pkg::pid_bad);
		send_eop();
		expect_response("bad PID", 1'b0, 1'b0, 1'b0, 1'b0);
		report_test("bad PID", start);
	endtask

	task automatic test_full_block();
		int start;
		start = errors;
		fill_block();
		load_block();
		check_value("host_ready at new_block", resp_host_ready, 1'b0);
		check_value("packet_type after DATA1", packet_type, pd_pkg::pid_data1);
		check_value("data_to_hash", data_to_hash, packed_header());
		check_value("difficulty", difficulty, packed_target());
		report_test("full block", start);
	endtask

	task automatic test_rejected_data();
		int               start;
		logic [HDR_W-1:0] old_header;
		logic [TGT_W-1:0] old_target;
		start      = errors;
		old_header = packed_header();
		old_target = packed_target();
		// New bytes, so an accepted packet would change the outputs
		fill_block();
		send_token(pd_pkg::PID_OUT, DEV_ADDR);
		expect_response("OUT before short header", 1'b1, 1'b0, 1'b0, 1'b0);
		send_header(pd_pkg::HEADER_BYTES - 1);
		expect_response("short header", 1'b0, 1'b1, 1'b0, 1'b0);
		check_value("data_to_hash kept", data_to_hash, old_header);
		send_target();
		expect_response("DATA1 without OUT", 1'b0, 1'b1, 1'b0, 1'b0);
		check_value("difficulty kept", difficulty, old_target);
		report_test("rejected data", start);
	endtask

	task automatic test_in_result();
		int start;
		start = errors;
		send_token(pd_pkg::PID_IN, DEV_ADDR);
		expect_response("IN before result", 1'b0, 1'b0, 1'b0, 1'b0);
		pulse_hash_done();
		@(negedge tb_clk);
		check_value("host_ready after hash_done", host_ready, 1'b1);
		send_token(pd_pkg::PID_IN, DEV_ADDR);
		expect_response("IN with result", 1'b1, 1'b0, 1'b0, 1'b0);
		send_token(pd_pkg::PID_IN, DEV_ADDR);
		expect_response("IN after result taken", 1'b0, 1'b0, 1'b0, 1'b0);
		report_test("IN and result", start);
	endtask

	task automatic test_interrupt();
		int start;
		start = errors;
		// Start a new block so host_ready is low first
		fill_block();
		load_block();
		check_value("host_ready before interrupt", resp_host_ready, 1'b0);
		send_token(pd_pkg::PID_OUT, DEV_ADDR);
		expect_response("OUT before interrupt", 1'b1, 1'b0, 1'b0, 1'b0);
		send_byte(pd_pkg::PID_DATA0);
		send_byte(pd_pkg::meta_interrupt);
		send_eop();
		expect_response("DATA0 interrupt", 1'b1, 1'b0, 1'b0, 1'b1);
		check_value("host_ready at hash_abort", resp_host_ready, 1'b1);
		check_value("data_to_hash", data_to_hash, packed_header());
		report_test("interrupt", start);
	endtask

	initial
	begin
		seed_init    = $urandom(81);
		rst_n        = 1'b0;
		write_enable = 1'b0;
		rx_data      = 8'h00;
		eop          = 1'b0;
		hash_done    = 1'b0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (10) @(posedge tb_clk);
		rst_n <= 1'b1;

		test_reset_and_out();
		test_bad_pid();
		test_full_block();
		test_rejected_data();
		test_in_result();
		test_interrupt();

		errors += pd_top_i.pd_response_i.pd_asserts_i.fail_count;
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire
